/* Bender.yml */
package:
  name: query_engine

sources:
  - include_dirs:
      - design
    files:
      - design/query_engine_pkg.sv
      - design/credit_fifo.sv
      - design/query_config_loader.sv
      - design/predicate_eval.sv
      - design/record_projector.sv
      - design/query_engine_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/query_engine_tb.sv

/* design/credit_fifo.sv */
`timescale 1ns/100ps

module credit_fifo
#(
	parameter int DEPTH = 4
)
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	input  query_engine_pkg::word_t in_data,
	input  logic                    pop,
	output logic                    fifo_valid,
	output query_engine_pkg::word_t fifo_data,
	output logic                    in_credit
);

	localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	query_engine_pkg::word_t mem [DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0]   count;

	assign fifo_valid = (count != '0);
	assign fifo_data  = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (in_valid)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end
		else
		begin
			in_credit <= pop; // one credit back per word taken
			if (in_valid)
				wr_ptr <= (wr_ptr == ptr_w'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* design/predicate_eval.sv */
`timescale 1ns/100ps
`include "query_engine_defines.svh"

module predicate_eval
(
	input  logic                            clk,
	input  logic                            rst,
	input  query_engine_pkg::query_params_t params,
	input  logic                            rec_valid,
	input  query_engine_pkg::rec_beat_t     rec,
	output logic                            rec_ready,
	input  logic                            advance,
	output logic                            match_valid,
	output logic                            match,
	output query_engine_pkg::rec_beat_t     beat
);

	localparam int sel_w = $clog2(`QE_NUM_COLS);

	query_engine_pkg::col_val_t   cols [`QE_NUM_COLS];
	query_engine_pkg::pred_bits_t eval_bits;
	query_engine_pkg::pred_bits_t s1_bits;
	query_engine_pkg::rec_beat_t  s1_beat;
	logic                         s1_valid;

	function automatic logic compare(query_engine_pkg::col_val_t col_val,
		query_engine_pkg::pred_op_t op, query_engine_pkg::col_val_t value);
		case (op)
			`QE_OP_EQ: compare = (col_val == value);
			`QE_OP_NE: compare = (col_val != value);
			`QE_OP_LT: compare = (col_val <  value);
			`QE_OP_GT: compare = (col_val >  value);
			`QE_OP_LE: compare = (col_val <= value);
			`QE_OP_GE: compare = (col_val >= value);
			default:   compare = 1'b0;
		endcase
	endfunction

	assign rec_ready = advance; // both stages move together

	////////////////////////////////////////////////////////////////////////////
	// stage 1, predicate compares
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int c = 0; c < `QE_NUM_COLS; c++)
			cols[c] = rec.data[c*`QE_COL_W +: `QE_COL_W];
		for (int i = 0; i < `QE_NUM_COLS; i++)
		begin
			if (params.preds[i].col < `QE_NUM_COLS)
				eval_bits[i] = compare(cols[params.preds[i].col[sel_w-1:0]],
					params.preds[i].op, params.preds[i].value);
			else
				eval_bits[i] = 1'b0; // no such column
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			s1_bits <= eval_bits;
			s1_beat <= rec;
			match   <= params.truth[s1_bits]; // stage 2 lookup
			beat    <= s1_beat;
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			s1_valid    <= 1'b0;
			match_valid <= 1'b0;
		end
		else if (advance)
		begin
			s1_valid    <= rec_valid;
			match_valid <= s1_valid;
		end
	end

endmodule

/* design/query_config_loader.sv */
`timescale 1ns/100ps
`include "query_engine_defines.svh"

module query_config_loader
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            fifo_valid,
	input  query_engine_pkg::word_t         fifo_data,
	output logic                            pop,
	input  logic                            rec_ready,
	output query_engine_pkg::query_params_t params,
	output logic                            rec_valid,
	output query_engine_pkg::rec_beat_t     rec
);

	// predicates that fit in the first predicate word
	localparam int lo_preds = $bits(query_engine_pkg::word_t) / $bits(query_engine_pkg::pred_t);
	localparam int pred_w   = $bits(query_engine_pkg::pred_t);
	localparam int cnt_w    = $bits(query_engine_pkg::rec_cnt_t);
	localparam int mask_w   = $bits(query_engine_pkg::col_mask_t);

	query_engine_pkg::cfg_state_t state;
	query_engine_pkg::rec_cnt_t   rec_left;
	logic [1:0]                   drain; // edges until last record clears stage 2

	assign rec_valid = (state == query_engine_pkg::records) && (rec_left != '0) && fifo_valid;
	assign pop       = (state == query_engine_pkg::records) ? (rec_valid && rec_ready) : fifo_valid;

	always_comb
	begin
		rec.data = fifo_data;
		rec.last = (rec_left == cnt_w'(1));
	end

	////////////////////////////////////////////////////////////////////////////
	// config words, layout
	//   word 0  count [15:0], mask [23:16]
	//   word 1  truth table
	//   word 2  predicates 0..4, 48 bits each from bit 0
	//   word 3  predicates 5..7
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (fifo_valid)
		begin
			case (state)
				query_engine_pkg::hdr:
				begin
					params.rec_cnt <= fifo_data[cnt_w-1:0];
					params.mask    <= fifo_data[cnt_w +: mask_w];
				end
				query_engine_pkg::truth:
					params.truth <= fifo_data;
				query_engine_pkg::pred_lo:
					for (int i = 0; i < lo_preds; i++)
						params.preds[i] <= fifo_data[i*pred_w +: pred_w];
				query_engine_pkg::pred_hi:
					for (int i = lo_preds; i < `QE_NUM_COLS; i++)
						params.preds[i] <= fifo_data[(i-lo_preds)*pred_w +: pred_w];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state    <= query_engine_pkg::hdr;
			rec_left <= '0;
			drain    <= '0;
		end
		else
		begin
			case (state)
				query_engine_pkg::hdr:
					if (fifo_valid)
						state <= query_engine_pkg::truth;
				query_engine_pkg::truth:
					if (fifo_valid)
						state <= query_engine_pkg::pred_lo;
				query_engine_pkg::pred_lo:
					if (fifo_valid)
						state <= query_engine_pkg::pred_hi;
				query_engine_pkg::pred_hi:
					if (fifo_valid)
					begin
						rec_left <= params.rec_cnt;
						drain    <= 2'd2;
						// empty query has nothing to stream
						state    <= (params.rec_cnt == '0) ? query_engine_pkg::hdr
							: query_engine_pkg::records;
					end
				query_engine_pkg::records:
					if (rec_left != '0)
					begin
						if (pop)
							rec_left <= rec_left - 1'b1;
					end
					else if (rec_ready)
					begin
						// params stay put until the pipeline is empty
						drain <= drain - 1'b1;
						if (drain == 2'd1)
							state <= query_engine_pkg::hdr;
					end
				default: state <= query_engine_pkg::hdr;
			endcase
		end
	end

endmodule

/* design/query_engine_defines.svh */
`ifndef QUERY_ENGINE_DEFINES_SVH
`define QUERY_ENGINE_DEFINES_SVH

// record geometry
`define QE_NUM_COLS   8     // columns per record, also predicate count
`define QE_COL_W      32
`define QE_WORD_W     256

// input side
`define QE_IN_DEPTH   4     // FIFO slots == sender start credits
`define QE_CFG_WORDS  4     // hdr, truth table, two predicate words

// predicate operators, unsigned compares
`define QE_OP_EQ      8'd0
`define QE_OP_NE      8'd1
`define QE_OP_LT      8'd2
`define QE_OP_GT      8'd3
`define QE_OP_LE      8'd4
`define QE_OP_GE      8'd5

`endif

/* design/query_engine_pkg.sv */
`include "query_engine_defines.svh"

package query_engine_pkg;

	typedef logic [`QE_COL_W-1:0]    col_val_t;
	typedef logic [`QE_WORD_W-1:0]   word_t;
	typedef logic [15:0]             rec_cnt_t;
	typedef logic [7:0]              pred_op_t;
	typedef logic [7:0]              col_sel_t;
	typedef logic [`QE_NUM_COLS-1:0] col_mask_t;  // bit i keeps column i
	typedef logic [`QE_NUM_COLS-1:0] pred_bits_t; // truth table index

	// op sits in the low byte of the 48 bit field
	typedef struct packed
	{
		col_val_t value;
		col_sel_t col;
		pred_op_t op;
	} pred_t;

	typedef struct packed
	{
		rec_cnt_t                    rec_cnt;
		col_mask_t                   mask;
		word_t                       truth;  // entry i is bit i
		pred_t [`QE_NUM_COLS-1:0]    preds;
	} query_params_t;

	typedef struct packed
	{
		logic  last;
		word_t data;
	} rec_beat_t;

	typedef enum logic [2:0]
	{
		hdr,
		truth,
		pred_lo,
		pred_hi,
		records
	} cfg_state_t;

endpackage

/* design/query_engine_top.sv */
`timescale 1ns/100ps
`include "query_engine_defines.svh"

module query_engine_top
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       in_valid,
	input  query_engine_pkg::word_t    in_data,
	output logic                       in_credit,
	input  logic                       out_credit,
	output logic                       out_valid,
	output query_engine_pkg::word_t    out_data,
	output logic                       query_done,
	output query_engine_pkg::rec_cnt_t match_count
);

	logic                            fifo_valid;
	query_engine_pkg::word_t         fifo_data;
	logic                            pop;
	query_engine_pkg::query_params_t params;
	logic                            rec_valid;
	query_engine_pkg::rec_beat_t     rec;
	logic                            rec_ready;
	logic                            match_valid;
	logic                            match;
	query_engine_pkg::rec_beat_t     beat;
	logic                            advance;

	credit_fifo #(.DEPTH(`QE_IN_DEPTH)) i_credit_fifo
	(
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.pop        (pop),
		.fifo_valid (fifo_valid),
		.fifo_data  (fifo_data),
		.in_credit  (in_credit)
	);

	query_config_loader i_query_config_loader
	(
		.clk        (clk),
		.rst        (rst),
		.fifo_valid (fifo_valid),
		.fifo_data  (fifo_data),
		.pop        (pop),
		.rec_ready  (rec_ready),
		.params     (params),
		.rec_valid  (rec_valid),
		.rec        (rec)
	);

	predicate_eval i_predicate_eval
	(
		.clk         (clk),
		.rst         (rst),
		.params      (params),
		.rec_valid   (rec_valid),
		.rec         (rec),
		.rec_ready   (rec_ready),
		.advance     (advance),
		.match_valid (match_valid),
		.match       (match),
		.beat        (beat)
	);

	record_projector i_record_projector
	(
		.clk         (clk),
		.rst         (rst),
		.params      (params),
		.match_valid (match_valid),
		.match       (match),
		.beat        (beat),
		.advance     (advance),
		.out_credit  (out_credit),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.query_done  (query_done),
		.match_count (match_count)
	);

endmodule

/* design/record_projector.sv */
`timescale 1ns/100ps
`include "query_engine_defines.svh"

module record_projector
(
	input  logic                            clk,
	input  logic                            rst,
	input  query_engine_pkg::query_params_t params,
	input  logic                            match_valid,
	input  logic                            match,
	input  query_engine_pkg::rec_beat_t     beat,
	output logic                            advance,
	input  logic                            out_credit,
	output logic                            out_valid,
	output query_engine_pkg::word_t         out_data,
	output logic                            query_done,
	output query_engine_pkg::rec_cnt_t      match_count
);

	query_engine_pkg::rec_cnt_t credits;
	query_engine_pkg::rec_cnt_t cnt;     // matches so far in this query
	query_engine_pkg::word_t    masked;
	logic                       leave;
	logic                       emit;

	// stall only a hit with nowhere to go
	assign advance = !(match_valid && match && (credits == '0));
	assign leave   = match_valid && advance;
	assign emit    = leave && match;

	always_comb
	begin
		for (int c = 0; c < `QE_NUM_COLS; c++)
			masked[c*`QE_COL_W +: `QE_COL_W] = params.mask[c]
				? beat.data[c*`QE_COL_W +: `QE_COL_W] : '0;
	end

	always_ff @(posedge clk)
	begin
		if (emit)
			out_data <= masked;
	end

	////////////////////////////////////////////////////////////////////////////
	// credits, match count, done
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			credits     <= '0;
			cnt         <= '0;
			out_valid   <= 1'b0;
			query_done  <= 1'b0;
			match_count <= '0;
		end
		else
		begin
			out_valid  <= emit;
			query_done <= leave && beat.last;
			case ({out_credit, emit})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
			if (leave && beat.last)
			begin
				match_count <= cnt + emit;
				cnt         <= '0;
			end
			else if (emit)
				cnt <= cnt + 1'b1;
		end
	end

endmodule

/* dv/query_engine_tb.sv */
`timescale 1ns/100ps
`include "query_engine_defines.svh"

module query_engine_tb;

	// records in each query, the operator test runs seven queries of n_op
	localparam int n_proj      = 6;
	localparam int n_op        = 8;
	localparam int n_two       = 10;
	localparam int n_bp        = 12;
	localparam int n_next      = 5;
	localparam int n_queries   = 11;
	localparam int total_words = n_queries*`QE_CFG_WORDS + n_proj + 7*n_op + n_two + n_bp + n_next;
	localparam int watchdog_ns = total_words*20 + 2000;
	localparam int pred_w      = $bits(query_engine_pkg::pred_t);
	localparam int per_word    = `QE_WORD_W / pred_w; // predicates in config word 2

	logic                       clk;
	logic                       rst;
	logic                       in_valid;
	query_engine_pkg::word_t    in_data;
	logic                       in_credit;
	logic                       out_credit;
	logic                       out_valid;
	query_engine_pkg::word_t    out_data;
	logic                       query_done;
	query_engine_pkg::rec_cnt_t match_count;

	query_engine_pkg::word_t    exp_out [$];
	query_engine_pkg::rec_cnt_t exp_cnt [$];
	integer seed = 19;
	int  errors = 0;
	int  sent = 0;
	int  returned = 0;
	int  given = 0;     // output credits granted
	int  out_idx = 0;
	int  done_idx = 0;
	bit  slow = 1'b0;

	query_engine_top i_query_engine_top
	(
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_credit   (in_credit),
		.out_credit  (out_credit),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.query_done  (query_done),
		.match_count (match_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic pred_true(query_engine_pkg::word_t r,
		query_engine_pkg::pred_t p);
		query_engine_pkg::col_val_t v;
		logic lt;
		logic eq;
		if (p.col >= `QE_NUM_COLS)
			return 1'b0;
		v  = r[int'(p.col)*`QE_COL_W +: `QE_COL_W];
		lt = v < p.value;
		eq = v == p.value;
		case (p.op)
			`QE_OP_EQ: return eq;
			`QE_OP_NE: return !eq;
			`QE_OP_LT: return lt;
			`QE_OP_GT: return !(lt || eq);
			`QE_OP_LE: return lt || eq;
			`QE_OP_GE: return !lt;
			default:   return 1'b0;
		endcase
	endfunction

	function automatic logic record_hit(query_engine_pkg::word_t r,
		query_engine_pkg::query_params_t q);
		query_engine_pkg::pred_bits_t idx;
		for (int i = 0; i < `QE_NUM_COLS; i++)
			idx[i] = pred_true(r, q.preds[i]);
		return q.truth[idx];
	endfunction

	function automatic query_engine_pkg::word_t project(query_engine_pkg::word_t r,
		query_engine_pkg::col_mask_t m);
		query_engine_pkg::word_t w;
		w = '0;
		for (int c = 0; c < `QE_NUM_COLS; c++)
			if (m[c])
				w[c*`QE_COL_W +: `QE_COL_W] = r[c*`QE_COL_W +: `QE_COL_W];
		return w;
	endfunction

	function automatic query_engine_pkg::query_params_t blank_query(int n);
		query_engine_pkg::query_params_t q;
		q         = '0;
		q.rec_cnt = 16'(n);
		q.mask    = '1;
		for (int i = 0; i < `QE_NUM_COLS; i++)
			q.preds[i].op = 8'hff; // unknown op never matches
		return q;
	endfunction

	function automatic query_engine_pkg::word_t cfg_word(query_engine_pkg::query_params_t q,
		int k);
		query_engine_pkg::word_t w;
		w = '0;
		if (k == 0)
		begin
			w[15:0]  = q.rec_cnt;
			w[23:16] = q.mask;
		end
		else if (k == 1)
			w = q.truth;
		else
			for (int i = 0; i < `QE_NUM_COLS; i++)
				if ((i < per_word) == (k == 2))
					w[(i % per_word)*pred_w +: pred_w] = q.preds[i];
		return w;
	endfunction

	function automatic query_engine_pkg::word_t expected_word(int idx);
		return (idx < exp_out.size()) ? exp_out[idx] : 'x;
	endfunction

	function automatic query_engine_pkg::rec_cnt_t expected_count(int idx);
		return (idx < exp_cnt.size()) ? exp_cnt[idx] : 'x;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic send_word(input query_engine_pkg::word_t w);
		while (sent - returned >= `QE_IN_DEPTH) // out of credits
		begin
			@(posedge clk);
			#1;
		end
		in_valid = 1'b1;
		in_data  = w;
		sent++;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic run_query(input query_engine_pkg::query_params_t q,
		input query_engine_pkg::col_val_t range);
		query_engine_pkg::word_t    recs [$];
		query_engine_pkg::word_t    w;
		query_engine_pkg::rec_cnt_t hits;
		hits = '0;
		for (int n = 0; n < q.rec_cnt; n++)
		begin
			for (int c = 0; c < `QE_NUM_COLS; c++)
				w[c*`QE_COL_W +: `QE_COL_W] = $random(seed) & range;
			recs.push_back(w);
			if (record_hit(w, q))
			begin
				exp_out.push_back(project(w, q.mask));
				hits++;
			end
		end
		exp_cnt.push_back(hits);
		for (int k = 0; k < `QE_CFG_WORDS; k++)
			send_word(cfg_word(q, k));
		foreach (recs[n])
			send_word(recs[n]);
	endtask

	task automatic wait_drained();
		while (out_idx < exp_out.size() || done_idx < exp_cnt.size())
			@(posedge clk);
		#1;
	endtask

	// output credits capped at the model's count
	initial
	begin
		int cyc;
		cyc        = 0;
		out_credit = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			out_credit = (given < exp_out.size()) && (!slow || cyc % 5 == 0);
			if (out_credit)
				given++;
			cyc++;
		end
	end

	always @(posedge clk)
	begin
		if (in_credit)
			returned++;
		if (out_valid)
			out_idx <= out_idx + 1;
		if (query_done)
			done_idx <= done_idx + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_out_data: assert property (@(posedge clk) disable iff (!rst)
		out_valid |-> (out_data === expected_word(out_idx)))
	else
	begin
		errors++;
		$display("** Error at %0t: out_data = %h, expected %h", $time,
			$sampled(out_data), expected_word($sampled(out_idx)));
	end

	a_out_credit: assert property (@(posedge clk) disable iff (!rst)
		out_valid |-> (out_idx < given))
	else
	begin
		errors++;
		$display("out_valid beat %0d sent without a granted credit", $sampled(out_idx));
	end

	a_done_count: assert property (@(posedge clk) disable iff (!rst)
		query_done |-> (match_count === expected_count(done_idx)))
	else
	begin
		errors++;
		$display("** Error at %0t: match_count = %0d, expected %0d", $time,
			$sampled(match_count), expected_count($sampled(done_idx)));
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
		query_done |=> !query_done)
	else
	begin
		errors++;
		$display("query_done stayed high for more than one cycle at %0t", $time);
	end

	a_in_credit: assert property (@(posedge clk) disable iff (!rst)
		in_credit |-> (returned < sent))
	else
	begin
		errors++;
		$display("in_credit returned with no word outstanding at %0t", $time);
	end

	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, run did not finish", watchdog_ns);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		query_engine_pkg::query_params_t q;
		query_engine_pkg::pred_op_t ops [6];
		ops      = '{`QE_OP_EQ, `QE_OP_NE, `QE_OP_LT, `QE_OP_GT, `QE_OP_LE, `QE_OP_GE};
		rst      = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b1;

		// projection with every record matching
		q        = blank_query(n_proj);
		q.truth  = '1;
		q.mask   = 8'b1010_0110;
		run_query(q, '1);

		// one operator at a time with truth following predicate 0
		foreach (ops[k])
		begin
			q                = blank_query(n_op);
			q.truth          = {128{2'b10}};
			q.preds[0].op    = ops[k];
			q.preds[0].col   = 8'(k + 1);
			q.preds[0].value = 32'd3;
			run_query(q, 32'h7);
		end
		q                = blank_query(n_op);
		q.truth          = {128{2'b10}};
		q.preds[0].op    = `QE_OP_GE;
		q.preds[0].col   = 8'd9; // no such column
		run_query(q, 32'h7);

		// both predicates needed
		q                = blank_query(n_two);
		q.truth          = 256'd1 << 3;
		q.preds[0].op    = `QE_OP_GT;
		q.preds[0].col   = 8'd1;
		q.preds[0].value = 32'd3;
		q.preds[1].op    = `QE_OP_LE;
		q.preds[1].col   = 8'd6;
		q.preds[1].value = 32'd4;
		run_query(q, 32'h7);

		// slow output credits
		slow    = 1'b1;
		q       = blank_query(n_bp);
		q.truth = '1;
		run_query(q, '1);
		wait_drained();
		slow = 1'b0;

		// new parameters after a finished query
		q                = blank_query(n_next);
		q.mask           = 8'h0f;
		q.truth          = {128{2'b01}};
		q.preds[0].op    = `QE_OP_GE;
		q.preds[0].col   = 8'd7;
		q.preds[0].value = 32'd4;
		run_query(q, 32'h7);
		wait_drained();
		repeat (4) @(posedge clk);

		a_credits_back: assert (returned == sent)
		else
		begin
			errors++;
			$display("** Error at %0t: credits returned = %0d, expected %0d", $time,
				returned, sent);
		end
		$display("errors: %0d, records out: %0d, queries done: %0d", errors, out_idx, done_idx);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* query_engine.f */
+incdir+design
design/query_engine_pkg.sv
design/credit_fifo.sv
design/query_config_loader.sv
design/predicate_eval.sv
design/record_projector.sv
design/query_engine_top.sv
dv/query_engine_tb.sv
